// ==== include/rv_core_cfg.svh ====
// configuration macros for the reset pc, data memory depth and register count.
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// address loaded into the program counter while reset is asserted.
`define RV_RESET_PC 32'h0000_0000

// data memory depth in 32-bit words.
// the memory is indexed with address bits [7:2], so 64 words fill that window.
`define RV_DMEM_WORDS 64

// integer register count of the base isa.
`define RV_NUM_REGS 32

`endif

// ==== source/rv_isa_pkg.sv ====
// rv32i opcode and funct constants, per-format instruction layouts and the instruction union.
package rv_isa_pkg;

    // major opcodes of the supported instructions.
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_alt = 7'b0100000; // selects sub and sra.

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // one instruction word seen through each encoding format.
    typedef union packed {
        rv_r_fmt_t   r;
        rv_i_fmt_t   i;
        rv_s_fmt_t   s;
        rv_b_fmt_t   b;
        rv_u_fmt_t   u;
        rv_j_fmt_t   j;
        logic [31:0] raw;
    } rv_instr_u;

endpackage

// ==== source/rv_core_pkg.sv ====
// core datapath types for addresses, format flags, alu operations, decode results and writeback.
package rv_core_pkg;

    typedef logic [31:0] rv_addr;

    // exactly one flag is raised per supported opcode.
    typedef struct packed {
        logic r;
        logic i;
        logic s;
        logic b;
        logic u;
        logic j;
    } rv_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu,
        alu_bgeu
    } rv_alu_op_e;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        rv_fmt_t    fmt;
        rv_alu_op_e alu_op;
        logic       reg_write;
    } rv_dec_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } rv_wb_t;

endpackage

// ==== source/rv_decode.sv ====
// rv32i decoder producing register indices, function fields, format flags and alu operation.
`timescale 1ns/1ns
module rv_decode
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  rv_instr_u instr_i,
    output rv_dec_t   dec_o
);

    rv_fmt_t    fmt;
    rv_alu_op_e alu_op;
    logic       alt;

    assign alt = (instr_i.r.funct7 == f7_alt); // bit 30 picks the alternate operation.

    always_comb begin
        fmt = '0;
        case (instr_i.r.opcode)
            op_reg:                   fmt.r = 1'b1;
            op_imm, op_load, op_jalr: fmt.i = 1'b1;
            op_store:                 fmt.s = 1'b1;
            op_branch:                fmt.b = 1'b1;
            op_lui, op_auipc:         fmt.u = 1'b1;
            op_jal:                   fmt.j = 1'b1;
            default:                  fmt = '0; // unsupported opcodes retire as a no-op.
        endcase
    end

    always_comb begin
        alu_op = alu_add; // loads, stores, jumps and upper immediates all use the adder.
        if (instr_i.r.opcode == op_reg || instr_i.r.opcode == op_imm) begin
            case (instr_i.r.funct3)
                f3_add_sub: alu_op = (alt && fmt.r) ? alu_sub : alu_add; // no subi exists.
                f3_sll:     alu_op = alu_sll;
                f3_slt:     alu_op = alu_slt;
                f3_sltu:    alu_op = alu_sltu;
                f3_xor:     alu_op = alu_xor;
                f3_srl_sra: alu_op = alt ? alu_sra : alu_srl;
                f3_or:      alu_op = alu_or;
                default:    alu_op = alu_and;
            endcase
        end else if (fmt.b) begin
            case (instr_i.b.funct3)
                f3_beq:  alu_op = alu_beq;
                f3_bne:  alu_op = alu_bne;
                f3_blt:  alu_op = alu_blt;
                f3_bge:  alu_op = alu_bge;
                f3_bltu: alu_op = alu_bltu;
                f3_bgeu: alu_op = alu_bgeu;
                default: alu_op = alu_add; // reserved encodings are never taken.
            endcase
        end
    end

    assign dec_o.rs1       = instr_i.r.rs1;
    assign dec_o.rs2       = instr_i.r.rs2;
    assign dec_o.rd        = instr_i.r.rd;
    assign dec_o.opcode    = instr_i.r.opcode;
    assign dec_o.funct3    = instr_i.r.funct3;
    assign dec_o.funct7    = instr_i.r.funct7;
    assign dec_o.fmt       = fmt;
    assign dec_o.alu_op    = alu_op;
    assign dec_o.reg_write = fmt.r | fmt.i | fmt.u | fmt.j; // stores and branches have no rd.

    // sampled on every change of the incoming word.
    a_fmt_onehot: assert property (@(instr_i.raw) $onehot0(fmt))
        else $error("rv_decode: more than one format flag raised");

endmodule

// ==== source/rv_imm_gen.sv ====
// immediate generator rebuilding the sign-extended i, s, b, u and j immediates.
`timescale 1ns/1ns
module rv_imm_gen
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  rv_instr_u   instr_i,
    input  rv_fmt_t     fmt_i,
    output logic [31:0] imm_o
);

    always_comb begin
        case (1'b1)
            fmt_i.r: imm_o = '0;
            fmt_i.i: imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
            fmt_i.s: imm_o = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                              instr_i.s.imm_4_0};
            fmt_i.b: imm_o = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                              instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
            fmt_i.u: imm_o = {instr_i.u.imm_31_12, 12'b0};
            fmt_i.j: imm_o = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                              instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== source/rv_regfile.sv ====
// integer register file with two asynchronous read ports, one write port and x0 tied to zero.
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_regfile (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        we_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < `RV_NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i; // x0 stays at its reset value.
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    a_x0_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i) regs[0] == '0)
        else $error("rv_regfile: x0 holds a nonzero value");

endmodule

// ==== source/rv_alu.sv ====
// alu for integer arithmetic, logic, shifts, set-less-than and branch compares.
`timescale 1ns/1ns
module rv_alu
    import rv_core_pkg::*;
(
    input  rv_alu_op_e  op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic [31:0] result_o,
    output logic        taken_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        result_o = '0;
        taken_o  = 1'b0;
        case (op_i)
            alu_add:  result_o = a_i + b_i;
            alu_sub:  result_o = a_i - b_i;
            alu_sll:  result_o = a_i << shamt;
            alu_slt:  result_o = {31'b0, lt_s};
            alu_sltu: result_o = {31'b0, lt_u};
            alu_xor:  result_o = a_i ^ b_i;
            alu_srl:  result_o = a_i >> shamt;
            alu_sra:  result_o = $unsigned($signed(a_i) >>> shamt);
            alu_or:   result_o = a_i | b_i;
            alu_and:  result_o = a_i & b_i;
            alu_beq:  taken_o  = (a_i == b_i);
            alu_bne:  taken_o  = (a_i != b_i);
            alu_blt:  taken_o  = lt_s;
            alu_bge:  taken_o  = !lt_s;
            alu_bltu: taken_o  = lt_u;
            default:  taken_o  = !lt_u; // bgeu.
        endcase
    end

endmodule

// ==== source/rv_dmem.sv ====
// word-addressed data memory with asynchronous read and clocked write.
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_dmem (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic        we_i,
    output logic [31:0] rdata_o
);

    localparam int aw = $clog2(`RV_DMEM_WORDS);

    logic [31:0]   mem [`RV_DMEM_WORDS];
    logic [aw-1:0] idx;

    assign idx = addr_i[aw+1:2]; // byte offset bits are dropped.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < `RV_DMEM_WORDS; k++) begin
                mem[k] <= '0;
            end
        end else if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[idx];

    // upper address bits would alias onto a lower word.
    a_store_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        we_i |-> (addr_i[31:2] < `RV_DMEM_WORDS))
        else $error("rv_dmem: store to address %h beyond memory", addr_i);

endmodule

// ==== source/rv_core.sv ====
// single-cycle rv32i core top level with program counter, next-pc logic and datapath muxes.
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      run_i,
    output rv_addr    pc_o,
    input  rv_instr_u instr_i,
    output rv_wb_t    wb_o
);

    rv_addr      pc_q;
    rv_addr      pc_next;
    rv_addr      pc_plus4;
    rv_addr      pc_plus_imm;
    rv_dec_t     dec;
    rv_wb_t      wb;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] mem_rdata;
    logic        taken;

    rv_decode u_decode (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    rv_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (dec.fmt),
        .imm_o   (imm)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rd_i       (wb.rd),
        .we_i       (wb.en),
        .wdata_i    (wb.data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign alu_b = (dec.fmt.r || dec.fmt.b) ? rs2_data : imm;

    rv_alu u_alu (
        .op_i     (dec.alu_op),
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .result_o (alu_result),
        .taken_o  (taken)
    );

    rv_dmem u_dmem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .addr_i   (alu_result),
        .wdata_i  (rs2_data),
        .we_i     (run_i && dec.fmt.s),
        .rdata_o  (mem_rdata)
    );

    assign pc_plus4    = pc_q + 32'd4;
    assign pc_plus_imm = pc_q + imm;

    always_comb begin
        if (dec.opcode == op_jalr) begin
            pc_next = {alu_result[31:1], 1'b0};
        end else if (taken || dec.fmt.j) begin
            pc_next = pc_plus_imm; // only branch ops can raise taken.
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        case (dec.opcode)
            op_load:         wb.data = mem_rdata;
            op_jal, op_jalr: wb.data = pc_plus4;
            op_lui:          wb.data = imm;
            op_auipc:        wb.data = pc_plus_imm;
            default:         wb.data = alu_result;
        endcase
    end

    assign wb.rd = dec.rd;
    assign wb.en = run_i && dec.reg_write && (dec.rd != 5'd0); // x0 targets retire silently.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (run_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;
    assign wb_o = wb;

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i) pc_q[1:0] == 2'b00)
        else $error("rv_core: pc %h is not word aligned", pc_q);

endmodule

// ==== test/tb_rv_core.sv ====
// testbench for rv_core with program generator, instruction memory, reference model and report.
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module tb_rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
;
    localparam int cycle_limit = 2 * 64 + 40; // forward-only jumps retire at most 64 words.
    localparam logic [31:0] loop_word = 32'h0000_006f; // jal x0, 0.

    logic      clk_i;
    logic      arst_n_i;
    logic      run_i;
    rv_addr    pc_o;
    rv_instr_u instr_i;
    rv_wb_t    wb_o;

    logic [31:0] imem [64];
    logic [31:0] regs_m [`RV_NUM_REGS];
    logic [31:0] mem_m [`RV_DMEM_WORDS];
    rv_addr      model_pc;
    logic [31:0] lfsr_q;
    logic        checking;
    logic        loop_hit;
    string       test_name;
    int          n;
    int          cycles;
    int          checks;
    int          errors;
    int          tests;

    rv_core i_dut (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .run_i    (run_i),
        .pc_o     (pc_o),
        .instr_i  (instr_i),
        .wb_o     (wb_o)
    );

    assign instr_i = imem[pc_o[7:2]];

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] rnd_bits(input int bits);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int k = 0; k < bits; k++) begin
            b      = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // executes the word at pc on the model state and returns the next pc.
    function automatic rv_addr ref_exec(input rv_addr pc, output rv_wb_t wb);
        logic [31:0] w, a, b, imm_i, imm_s, imm_b, imm_u, imm_j, res, addr;
        logic        has_rd;
        rv_addr      nxt;
        w      = imem[pc[7:2]];
        a      = regs_m[w[19:15]];
        b      = regs_m[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u  = {w[31:12], 12'b0};
        imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        nxt    = pc + 4;
        res    = '0;
        has_rd = 1'b1;
        wb     = '0;
        case (w[6:0])
            op_lui:   res = imm_u;
            op_auipc: res = pc + imm_u;
            op_jal: begin
                res = pc + 4;
                nxt = pc + imm_j;
            end
            op_jalr: begin
                res = pc + 4;
                nxt = (a + imm_i) & ~32'd1;
            end
            op_branch: begin
                has_rd = 1'b0;
                if (taken_ref(w[14:12], a, b)) nxt = pc + imm_b;
            end
            op_load: begin
                addr = a + imm_i;
                res  = mem_m[addr[7:2]];
            end
            op_store: begin
                has_rd = 1'b0;
                addr   = a + imm_s;
                mem_m[addr[7:2]] = b;
            end
            op_imm:  res = alu_ref(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
            op_reg:  res = alu_ref(w[14:12], w[30], a, b);
            default: has_rd = 1'b0; // unsupported words retire as no-ops.
        endcase
        if (has_rd && w[11:7] != 5'd0) begin
            wb.en   = 1'b1;
            wb.rd   = w[11:7];
            wb.data = res;
            regs_m[w[11:7]] = res;
        end
        return nxt;
    endfunction

    task automatic check_pc(input string name, input rv_addr exp, input rv_addr act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s pc: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_wb(input string name, input rv_wb_t exp, input rv_wb_t act);
        checks++;
        if (act.en !== exp.en || (exp.en && act !== exp)) begin
            errors++;
            $display("mismatch %s wb: expected %h actual %h", name, exp, act);
        end
    endtask

    // compares at the falling edge, where the combinational path has settled.
    always @(negedge clk_i) begin
        rv_wb_t exp_wb;
        rv_addr nxt;
        if (checking) begin
            if (run_i) begin
                nxt = ref_exec(model_pc, exp_wb);
                check_pc(test_name, model_pc, pc_o);
                check_wb(test_name, exp_wb, wb_o);
                if (nxt == model_pc) loop_hit = 1'b1;
                model_pc = nxt;
            end else begin
                check_pc(test_name, model_pc, pc_o);
                checks++;
                if (wb_o.en !== 1'b0) begin
                    errors++;
                    $display("%s: write enable raised while the core is stalled", test_name);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        if (checking && run_i) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("%s: timeout, no self-loop after %0d cycles", test_name, cycles);
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic put(input logic [31:0] w);
        imem[n] = w;
        n++;
    endtask

    task automatic clear_program();
        n = 0;
        for (int k = 0; k < 64; k++) imem[k] = loop_word;
    endtask

    task automatic load_arith();
        clear_program();
        put(enc_i(-12'sd5, 0, 3'd0, 1, op_imm));
        put(enc_i(12'd7, 0, 3'd0, 2, op_imm));
        put({20'h80000, 5'd3, op_lui});
        put(enc_i(12'd31, 0, 3'd0, 7, op_imm));
        for (int f = 0; f < 8; f++) put(enc_r(7'd0, 2, 1, f[2:0], 5'(8 + f)));
        put(enc_r(f7_alt, 2, 1, 3'd0, 16)); // sub with a negative result.
        put(enc_r(7'd0, 7, 1, 3'd1, 17));
        put(enc_r(7'd0, 7, 3, 3'd5, 18));
        put(enc_r(f7_alt, 7, 3, 3'd5, 19));
        for (int f = 2; f < 8; f++) begin
            if (f != 5) put(enc_i(-12'sd3, 1, f[2:0], 5'(18 + f), op_imm));
        end
        put(enc_i(12'd31, 1, 3'd1, 26, op_imm));
        put(enc_i(12'd31, 3, 3'd5, 27, op_imm));
        put(enc_i({7'b0100000, 5'd31}, 3, 3'd5, 28, op_imm));
        put(enc_i(12'd5, 1, 3'd0, 0, op_imm)); // writes to x0 must vanish.
        put(enc_r(7'd0, 2, 1, 3'd0, 0));
        put(enc_r(7'd0, 0, 0, 3'd0, 29));
    endtask

    task automatic load_mem();
        clear_program();
        put(enc_i(12'd123, 0, 3'd0, 1, op_imm));
        put(enc_i(-12'sd1, 0, 3'd0, 2, op_imm));
        put(enc_s(12'd8, 1));
        put(enc_s(12'd12, 2));
        put(enc_i(12'd8, 0, 3'b010, 3, op_load));
        put(enc_i(12'd12, 0, 3'b010, 4, op_load));
        put(enc_i(12'd40, 0, 3'b010, 5, op_load));
        put(enc_s(12'd8, 2));
        put(enc_i(12'd8, 0, 3'b010, 6, op_load));
        put(enc_i(12'd252, 0, 3'b010, 7, op_load));
    endtask

    task automatic load_ctrl();
        clear_program();
        put(enc_i(12'd5, 0, 3'd0, 1, op_imm));
        put(enc_i(-12'sd3, 0, 3'd0, 2, op_imm));
        // each compare once taken over a marker and once not taken.
        put(enc_b(13'd8, 1, 1, 3'd0));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_b(13'd8, 2, 1, 3'd0));
        put(enc_b(13'd8, 2, 1, 3'd1));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_b(13'd8, 1, 1, 3'd1));
        put(enc_b(13'd8, 1, 2, 3'd4));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_b(13'd8, 2, 1, 3'd4));
        put(enc_b(13'd8, 2, 1, 3'd5));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_b(13'd8, 1, 2, 3'd5));
        put(enc_b(13'd8, 2, 1, 3'd6));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_b(13'd8, 1, 2, 3'd6));
        put(enc_b(13'd8, 1, 2, 3'd7));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_b(13'd8, 2, 1, 3'd7));
        put(enc_j(21'd8, 5));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put(enc_i(12'((n + 2) * 4), 0, 3'd0, 6, op_jalr));
        put(enc_i(12'd1, 0, 3'd0, 9, op_imm));
        put({20'habcde, 5'd7, op_lui});
        put({20'h12345, 5'd8, op_auipc});
    endtask

    task automatic load_random();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [31:0] step;
        clear_program();
        for (int k = 0; k < 63; k++) begin
            kind = rnd_bits(3);
            f3   = rnd_bits(3);
            step = (rnd_bits(2) + 1) * 4; // forward 4 to 16 bytes.
            if (k + step / 4 > 63) step = (63 - k) * 4;
            case (kind)
                3'd0: put(enc_r((f3 == 3'd0 || f3 == 3'd5) && rnd_bits(1) ? f7_alt : 7'd0,
                                rnd_bits(5), rnd_bits(5), f3, rnd_bits(5)));
                3'd1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        put(enc_i({f3 == 3'd5 && rnd_bits(1) ? 7'b0100000 : 7'd0,
                                   5'(rnd_bits(5))}, rnd_bits(5), f3, rnd_bits(5), op_imm));
                    end else begin
                        put(enc_i(rnd_bits(12), rnd_bits(5), f3, rnd_bits(5), op_imm));
                    end
                end
                3'd2: put(enc_i(12'(rnd_bits(6) * 4), 0, 3'b010, rnd_bits(5), op_load));
                3'd3: put(enc_s(12'(rnd_bits(6) * 4), rnd_bits(5)));
                3'd4: put(enc_b(13'(step), rnd_bits(5), rnd_bits(5),
                                (f3 == 3'd2 || f3 == 3'd3) ? f3 + 3'd2 : f3));
                3'd5: put(enc_j(21'(step), rnd_bits(5)));
                3'd6: put(enc_i(12'(k * 4 + step), 0, 3'd0, rnd_bits(5), op_jalr));
                default: put({20'(rnd_bits(20)), 5'(rnd_bits(5)),
                              rnd_bits(1) ? op_lui : op_auipc});
            endcase
        end
    endtask

    task automatic do_reset();
        @(posedge clk_i);
        arst_n_i <= 1'b0;
        run_i    <= 1'b0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        for (int k = 0; k < `RV_NUM_REGS; k++) regs_m[k] = '0;
        for (int k = 0; k < `RV_DMEM_WORDS; k++) mem_m[k] = '0;
        model_pc = `RV_RESET_PC;
        loop_hit = 1'b0;
        cycles   = 0;
    endtask

    task automatic run_test(input string name, input logic stall);
        int err_start;
        err_start = errors;
        test_name = name;
        do_reset();
        checking = 1'b1;
        while (!loop_hit) begin
            @(posedge clk_i);
            run_i <= stall ? (rnd_bits(2) != 0) : 1'b1;
        end
        repeat (4) @(posedge clk_i) run_i <= 1'b1; // the pc must sit on the loop.
        @(posedge clk_i);
        run_i <= 1'b0;
        @(posedge clk_i);
        checking = 1'b0;
        tests++;
        $display("test %s: %s", name, errors == err_start ? "ok" : "failed");
    endtask

    initial begin
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        run_i    = 1'b0;
        checking = 1'b0;
        lfsr_q   = 32'h141a;
        checks   = 0;
        errors   = 0;
        tests    = 0;
        load_arith();

        test_name = "reset";
        do_reset();
        checking = 1'b1; // run_i stays low, so the pc must hold.
        repeat (6) @(posedge clk_i);
        checking = 1'b0;
        tests++;
        $display("test reset: %s", errors == 0 ? "ok" : "failed");

        load_arith();
        run_test("arithmetic", 1'b0);
        load_mem();
        run_test("load_store", 1'b0);
        load_ctrl();
        run_test("control_flow", 1'b0);
        load_random();
        run_test("random_program", 1'b0);
        load_random();
        run_test("stall", 1'b1);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_decode.sv
source/rv_imm_gen.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_dmem.sv
source/rv_core.sv
test/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/rv_isa_pkg.sv
      - source/rv_core_pkg.sv
      - source/rv_decode.sv
      - source/rv_imm_gen.sv
      - source/rv_regfile.sv
      - source/rv_alu.sv
      - source/rv_dmem.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_rv_core.sv
